//--- tests/icache_vectors.hex
// core request byte addresses, one per line, word aligned
// index is addr[7:4], word offset addr[3:2], tag addr[31:8]
00000100
00000104
00000108
0000010c
00000100
00000210
0000021c
00000214
00000218
00000210
00003300
0000330c
00000104
00000108
00003304
00000a50
00000a5c
00001a50
00000a54
12345670
12345678
1234567c
12345674
fedcba90
fedcba9c
0000f0f0
0000f0f4
0000f0f0

//--- icache_top.f
hdl/cache_pkg.sv
hdl/bus_pkg.sv
hdl/line_ram.sv
hdl/return_buffer.sv
hdl/refill_ctrl.sv
hdl/icache_lookup.sv
hdl/icache_top.sv
tests/icache_properties.sv
tests/tb_icache.sv

//--- Makefile
# Verilator build and run of the icache testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_icache
RTL_TOP    ?= icache_top
FILELIST   ?= icache_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only --timing
SIM_ARGS   ?= +verilator+error+limit+1000
SOURCES    := $(wildcard hdl/*.sv tests/*.sv)
SIM_BIN    := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# the log decides the result, the simulator status alone is not enough
run: build
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_icache.sv
// icache testbench
// replays request addresses from the vector file and plays burst memory
`timescale 1ns/100ps

module tb_icache;
    import cache_pkg::*;
    import bus_pkg::*;

    localparam int          max_vectors  = 64;
    localparam int          reset_cycles = 8;
    localparam logic [31:0] end_mark     = 32'hffff_ffff;

    logic        clk;
    logic        rstn;
    logic        req;
    logic [31:0] addr;
    logic        busy;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        rready;
    logic [beat_width-1:0] rdata;
    logic        rlast;

    logic [31:0]         vectors [max_vectors];
    tag_t                model_tag [num_sets];
    logic [num_sets-1:0] model_valid;
    int num_vectors;
    int timeout_limit;
    int cycles;
    int data_errors;
    int protocol_errors;
    int mem_req_seen;
    int misses_expected;

    icache_top dut (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .addr       (addr),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast)
    );

    bind refill_ctrl icache_properties props (
        .clk      (clk),
        .rstn     (rstn),
        .mem_req  (mem_req),
        .line_ok  (line_ok),
        .fill_ack (fill_ack)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rstn && mem_req)
            mem_req_seen <= mem_req_seen + 1;
    end

    // low half holds the word address and high half its inverse
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        logic [15:0] low;
        low = byte_addr[17:2];
        return {~low, low};
    endfunction

    task automatic log_protocol_error(input string what);
        protocol_errors++;
        $display("protocol error: %s", what);
    endtask

    task automatic check_word(input logic [31:0] a);
        logic [31:0] expected;
        expected = mem_word(a);
        assert (resp_data == expected) else begin
            data_errors++;
            $display("[FAIL] resp_data for addr %08h: got %08h, expected %08h",
                     a, resp_data, expected);
        end
    endtask

    // beats in ascending word order with random gaps
    task automatic send_line(input logic [31:0] line_addr);
        int gap;
        for (int beat = 0; beat < burst_len; beat++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(negedge clk);
                assert (!resp_valid) else log_protocol_error("response before the line arrived");
            end
            assert (mem_addr == line_addr) else begin
                protocol_errors++;
                $display("[FAIL] mem_addr during burst: got %08h, expected %08h",
                         mem_addr, line_addr);
            end
            rready = 1'b1;
            rdata  = mem_word(line_addr + 32'(4 * beat));
            rlast  = (beat == burst_len - 1);
            @(negedge clk);
            rready = 1'b0;
            rlast  = 1'b0;
            assert (!resp_valid) else log_protocol_error("response before the line was written");
        end
    endtask

    task automatic run_request(input logic [31:0] a);
        logic [index_width-1:0] set_idx;
        tag_t                   tag;
        logic [31:0]            line_addr;
        logic                   hit;
        int                     wait_count;
        set_idx   = a[index_lsb +: index_width];
        tag       = a[tag_lsb +: tag_width];
        line_addr = a & ~32'((beat_width / 8) * burst_len - 1);
        hit       = model_valid[set_idx] && (model_tag[set_idx] == tag);
        assert (!busy) else log_protocol_error("cache still busy when a request was due");
        req  = 1'b1;
        addr = a;
        @(negedge clk);
        req = 1'b0;
        if (hit) begin
            assert (resp_valid) else log_protocol_error("no response one cycle after a hit");
            assert (!mem_req) else log_protocol_error("memory request on a hit");
            check_word(a);
        end else begin
            misses_expected++;
            assert (mem_req) else log_protocol_error("no memory request after a miss");
            assert (busy) else log_protocol_error("busy low during a miss");
            assert (!resp_valid) else log_protocol_error("response on a predicted miss");
            assert (mem_addr == line_addr) else begin
                protocol_errors++;
                $display("[FAIL] mem_addr: got %08h, expected %08h", mem_addr, line_addr);
            end
            send_line(line_addr);
            wait_count = 0;
            while (!resp_valid && wait_count < 8) begin
                @(negedge clk);
                wait_count++;
            end
            assert (resp_valid) else log_protocol_error("no response after the refill");
            assert (!busy) else log_protocol_error("busy still high with the refill response");
            check_word(a);
            model_valid[set_idx] = 1'b1;
            model_tag[set_idx]   = tag;
        end
        @(negedge clk);
        assert (!resp_valid) else log_protocol_error("resp_valid held longer than one cycle");
    endtask

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        req             = 1'b0;
        addr            = '0;
        rready          = 1'b0;
        rdata           = '0;
        rlast           = 1'b0;
        cycles          = 0;
        timeout_limit   = 0;
        data_errors     = 0;
        protocol_errors = 0;
        mem_req_seen    = 0;
        misses_expected = 0;
        model_valid     = '0;
        void'($urandom(32'h07655869));

        foreach (vectors[i])
            vectors[i] = end_mark;
        $readmemh("tests/icache_vectors.hex", vectors);
        num_vectors = 0;
        while (num_vectors < max_vectors && vectors[num_vectors] != end_mark)
            num_vectors++;
        timeout_limit = num_vectors * 40;
        assert (num_vectors > 0) else log_protocol_error("vector file gave no addresses");

        repeat (reset_cycles) @(negedge clk);
        assert (!resp_valid && !busy && !mem_req)
            else log_protocol_error("outputs not idle during reset");
        rstn = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_vectors; i++)
            run_request(vectors[i]);

        @(negedge clk);
        assert (mem_req_seen == misses_expected) else begin
            protocol_errors++;
            $display("[FAIL] mem_req pulses: got %0h, expected %0h", mem_req_seen, misses_expected);
        end

        $display("requests %0d, data errors %0d, protocol errors %0d, property failures %0d",
                 num_vectors, data_errors, protocol_errors, dut.refill.props.fail_count);
        if (data_errors + protocol_errors + dut.refill.props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/icache_properties.sv
// refill protocol checks
// bound into the refill controller, watches its exchange with the return buffer
`timescale 1ns/100ps

module icache_properties (
    input logic clk,
    input logic rstn,
    input logic mem_req,
    input logic line_ok,
    input logic fill_ack
);
    int fail_count = 0;

    // a new burst would overwrite the held line
    property no_req_while_line_held;
        @(posedge clk) disable iff (!rstn)
        !(mem_req && line_ok);
    endproperty

    // ack only in the first cycle of a held line
    property ack_needs_line;
        @(posedge clk) disable iff (!rstn)
        fill_ack |-> $rose(line_ok);
    endproperty

    property line_drops_after_ack;
        @(posedge clk) disable iff (!rstn)
        fill_ack |=> !line_ok;
    endproperty

    req_vs_line: assert property (no_req_while_line_held) else begin
        fail_count++;
        $error("mem_req pulsed while line_ok was high");
    end

    ack_in_send: assert property (ack_needs_line) else begin
        fail_count++;
        $error("fill_ack outside the first cycle of a held line");
    end

    line_cleared: assert property (line_drops_after_ack) else begin
        fail_count++;
        $error("line_ok still high the cycle after fill_ack");
    end

endmodule

//--- hdl/icache_top.sv
// L1 instruction cache
// direct-mapped read-only cache with burst refill from memory
`timescale 1ns/100ps

module icache_top (
    input  logic                           clk,
    input  logic                           rstn,
    // core side
    input  logic                           req,
    input  logic [31:0]                    addr,
    output logic                           busy,
    output logic                           resp_valid,
    output logic [31:0]                    resp_data,
    // memory side
    output logic                           mem_req,
    output logic [31:0]                    mem_addr,
    input  logic                           rready,
    input  logic [bus_pkg::beat_width-1:0] rdata,
    input  logic                           rlast
);
    import cache_pkg::*;

    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic                   tag_ok;
    logic                   data_ok;
    logic                   line_valid;
    tag_t                   tag_rd;
    tag_t                   wr_tag;
    line_t                  line_rd;
    line_t                  line_data;
    logic                   miss;
    logic [31:0]            miss_addr;
    logic                   line_ok;
    logic                   fill_ack;
    logic                   wr_en;
    logic                   fill_done;

    assign line_valid = tag_ok && data_ok;

    icache_lookup lookup (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .addr       (addr),
        .tag_valid  (line_valid),
        .tag_rd     (tag_rd),
        .line_rd    (line_rd),
        .line_data  (line_data),
        .fill_done  (fill_done),
        .rd_index   (rd_index),
        .miss       (miss),
        .miss_addr  (miss_addr),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

    refill_ctrl refill (
        .clk       (clk),
        .rstn      (rstn),
        .miss      (miss),
        .miss_addr (miss_addr),
        .line_ok   (line_ok),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .fill_ack  (fill_ack),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .fill_done (fill_done),
        .busy      (busy)
    );

    return_buffer rbuf (
        .clk       (clk),
        .rstn      (rstn),
        .rready    (rready),
        .rdata     (rdata),
        .rlast     (rlast),
        .fill_ack  (fill_ack),
        .line_ok   (line_ok),
        .line_data (line_data)
    );

    line_ram #(.payload_t(tag_t)) tag_store (
        .clk        (clk),
        .rstn       (rstn),
        .rd_index   (rd_index),
        .rd_valid   (tag_ok),
        .rd_payload (tag_rd),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_payload (wr_tag)
    );

    line_ram #(.payload_t(line_t)) data_store (
        .clk        (clk),
        .rstn       (rstn),
        .rd_index   (rd_index),
        .rd_valid   (data_ok),
        .rd_payload (line_rd),
        .wr_en      (wr_en),
        .wr_index   (wr_index),
        .wr_payload (line_data)   // straight from the buffer
    );

endmodule

//--- hdl/icache_lookup.sv
// icache lookup
// tag compare and word select, answers hits at once and misses after the fill
`timescale 1ns/100ps

module icache_lookup (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              req,
    input  logic [31:0]                       addr,
    input  logic                              tag_valid,
    input  cache_pkg::tag_t                   tag_rd,
    input  cache_pkg::line_t                  line_rd,
    input  cache_pkg::line_t                  line_data,
    input  logic                              fill_done,
    output logic [cache_pkg::index_width-1:0] rd_index,
    output logic                              miss,
    output logic [31:0]                       miss_addr,
    output logic                              resp_valid,
    output logic [31:0]                       resp_data
);
    import cache_pkg::*;

    logic                    req_q;
    logic                    pending;
    logic                    hit;
    logic [31:0]             addr_q;
    line_t                   fill_line;
    logic [offset_width-1:0] word_sel;

    assign rd_index = addr[index_lsb +: index_width];  // stores read on the req edge

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            req_q <= req;
            if (miss)
                pending <= 1'b1;
            else if (fill_done)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req)
            addr_q <= addr;
        if (pending)
            fill_line <= line_data;  // buffer clears on the fill edge
    end

    assign hit       = tag_valid && (tag_rd == addr_q[tag_lsb +: tag_width]);
    assign miss      = req_q && !hit;
    assign miss_addr = addr_q;
    assign word_sel  = addr_q[offset_lsb +: offset_width];

    assign resp_valid = (req_q && hit) || fill_done;

    always_comb begin
        if (fill_done)
            resp_data = fill_line[word_sel*word_width +: word_width];
        else
            resp_data = line_rd[word_sel*word_width +: word_width];
    end

endmodule

//--- hdl/refill_ctrl.sv
// icache refill controller
// turns a miss into a memory burst, then writes tag and line into the stores
`timescale 1ns/100ps

module refill_ctrl (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              miss,
    input  logic [31:0]                       miss_addr,
    input  logic                              line_ok,
    output logic                              mem_req,
    output logic [31:0]                       mem_addr,
    output logic                              fill_ack,
    output logic                              wr_en,
    output logic [cache_pkg::index_width-1:0] wr_index,
    output cache_pkg::tag_t                   wr_tag,
    output logic                              fill_done,
    output logic                              busy
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_line,
        fill
    } state_t;

    state_t      state;
    state_t      next_state;
    logic [31:0] line_addr;
    logic [31:0] miss_line;

    assign miss_line = {miss_addr[31:index_lsb], {index_lsb{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (mem_req)
            line_addr <= miss_line;
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (miss)
                    next_state = wait_line;
            end
            wait_line: begin
                if (line_ok)
                    next_state = fill;
            end
            fill:    next_state = idle;   // lookup answers here
            default: next_state = idle;
        endcase
    end

    // burst goes out in the miss cycle itself
    assign mem_req  = (state == idle) && miss;
    assign mem_addr = (state == idle) ? miss_line : line_addr;

    assign fill_ack  = (state == wait_line) && line_ok;
    assign wr_en     = fill_ack;
    assign wr_index  = line_addr[index_lsb +: index_width];
    assign wr_tag    = line_addr[tag_lsb +: tag_width];
    assign fill_done = (state == fill);

    assign busy = mem_req || (state == wait_line);

endmodule

//--- hdl/return_buffer.sv
// refill return buffer
// shifts burst beats into one line and holds it until the fill is acknowledged
`timescale 1ns/100ps

module return_buffer (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           rready,
    input  logic [bus_pkg::beat_width-1:0] rdata,
    input  logic                           rlast,
    input  logic                           fill_ack,
    output logic                           line_ok,
    output cache_pkg::line_t               line_data
);
    import cache_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {
        idle,
        receive,
        send
    } state_t;

    state_t state;
    state_t next_state;
    line_t  line_q;
    logic   beat_in;

    // beats are not expected while a line is waiting
    assign beat_in = rready && (state != send);

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (rready)
                    next_state = rlast ? send : receive;
            end
            receive: begin
                if (rready && rlast)
                    next_state = send;
            end
            send: begin
                if (fill_ack)
                    next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    // new beat enters at the top, word 0 ends up lowest
    always_ff @(posedge clk) begin
        if (beat_in)
            line_q <= {rdata, line_q[line_bits-1:beat_width]};
        else if (fill_ack && state == send)
            line_q <= '0;
    end

    assign line_ok   = (state == send);
    assign line_data = line_q;

endmodule

//--- hdl/line_ram.sv
// set-indexed line store
// one payload and a valid bit per set, synchronous read
`timescale 1ns/100ps

module line_ram #(
    parameter type payload_t = logic [31:0]
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [cache_pkg::index_width-1:0] rd_index,
    output logic                              rd_valid,
    output payload_t                          rd_payload,
    input  logic                              wr_en,
    input  logic [cache_pkg::index_width-1:0] wr_index,
    input  payload_t                          wr_payload
);
    import cache_pkg::*;

    payload_t           mem [num_sets];
    logic [num_sets-1:0] valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_en)
                valid[wr_index] <= 1'b1;
            rd_valid <= valid[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_index] <= wr_payload;
        rd_payload <= mem[rd_index];  // old data on a same-cycle write
    end

endmodule

//--- hdl/bus_pkg.sv
// memory burst bus
// beat width and burst length of the refill read
package bus_pkg;

    localparam int beat_width = 32;
    localparam int burst_len  = 4;  // one line per burst

endpackage

//--- hdl/cache_pkg.sv
// icache geometry
// address split and the tag and line types of the L1 instruction cache
package cache_pkg;

    localparam int word_width   = 32;
    localparam int offset_width = 2;    // 4 words per line
    localparam int index_width  = 4;    // 16 sets
    localparam int byte_width   = 2;
    localparam int tag_width    = 32 - index_width - offset_width - byte_width;
    localparam int line_bits    = word_width << offset_width;
    localparam int num_sets     = 1 << index_width;

    // bit positions inside a byte address
    localparam int offset_lsb = byte_width;
    localparam int index_lsb  = offset_lsb + offset_width;
    localparam int tag_lsb    = index_lsb + index_width;

    typedef logic [tag_width-1:0] tag_t;
    typedef logic [line_bits-1:0] line_t;  // word 0 in the low 32 bits

endpackage
